// File: id_stage.f
source/id_decode_pkg.sv
source/ctrl_decoder.sv
source/imm_gen.sv
source/operand_mux.sv
source/id_ex_reg.sv
source/id_stage.sv
testbench/tb_id_stage.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the ID stage testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! command -v verilator > /dev/null 2>&1; then
    echo "verilator was not found in PATH"
    exit 1
fi

verilator --binary --timing --timescale 1ns/1ps \
    --top-module tb_id_stage -f id_stage.f \
    --Mdir obj_dir -o sim_id_stage
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/sim_id_stage)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -qxF '*** PASSED ***'; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// File: source/ctrl_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module ctrl_decoder (
    input  logic [id_decode_pkg::XLEN-1:0] insn_i,
    input  logic                           en_i,
    output id_decode_pkg::alu_op_e         alu_op_o,
    output id_decode_pkg::cmp_op_e         cmp_op_o,
    output id_decode_pkg::mem_op_e         mem_op_o,
    output id_decode_pkg::ex_out_sel_e     ex_out_sel_o,
    output id_decode_pkg::imm_fmt_e        imm_fmt_o,
    output id_decode_pkg::src_a_e          src_a_o,
    output id_decode_pkg::src_b_e          src_b_o,
    output id_decode_pkg::wb_src_e         wb_src_o,
    output logic                           gpr_we_n_o,
    output logic                           jump_taken_o,
    output logic [1:0]                     src_reg_used_o
);

    import id_decode_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       is_r;    // Register form of the ALU group
    logic       f7_base; // funct7 acceptable for a plain ALU op

    assign opcode  = opcode_e'(insn_i[6:0]);
    assign funct3  = insn_i[14:12];
    assign funct7  = insn_i[31:25];
    assign is_r    = (opcode == OP_ALU);
    assign f7_base = !is_r || (funct7 == F7_BASE); // Immediate forms have no funct7

    always_comb begin
        alu_op_o       = ALU_NOP; // Idle defaults
        cmp_op_o       = CMP_NOP;
        mem_op_o       = MEM_NOP;
        ex_out_sel_o   = EX_OUT_ALU;
        imm_fmt_o      = IMM_I;
        src_a_o        = SRC_A_RA;
        src_b_o        = SRC_B_RB;
        wb_src_o       = WB_LINK;
        gpr_we_n_o     = 1'b1;
        jump_taken_o   = 1'b0;
        src_reg_used_o = 2'b00;

        if (en_i) begin
            case (opcode)
                OP_LOAD: begin
                    src_reg_used_o = 2'b01;
                    src_b_o        = SRC_B_IMM;
                    case (funct3)
                        F3_LB:   mem_op_o = MEM_LB;
                        F3_LH:   mem_op_o = MEM_LH;
                        F3_LW:   mem_op_o = MEM_LW;
                        F3_LBU:  mem_op_o = MEM_LBU;
                        F3_LHU:  mem_op_o = MEM_LHU;
                        default: mem_op_o = MEM_NOP;
                    endcase
                    if (mem_op_o != MEM_NOP) begin
                        alu_op_o   = ALU_ADD; // Address is ra + imm
                        gpr_we_n_o = 1'b0;
                    end
                end
                OP_ALUI, OP_ALU: begin
                    src_reg_used_o = is_r ? 2'b11 : 2'b01;
                    src_b_o        = is_r ? SRC_B_RB : SRC_B_IMM;
                    case (funct3)
                        F3_ADDI: begin
                            if (f7_base) begin
                                alu_op_o = ALU_ADD;
                            end else if (funct7 == F7_ALT) begin
                                alu_op_o = ALU_SUB; // Only reached for register form
                            end
                        end
                        F3_SLLI: begin
                            imm_fmt_o = IMM_I_SHR;
                            if (funct7 == F7_BASE) alu_op_o = ALU_SLL;
                        end
                        F3_SLTI:  if (f7_base) cmp_op_o = CMP_LT;
                        F3_SLTIU: if (f7_base) cmp_op_o = CMP_LTU;
                        F3_XORI:  if (f7_base) alu_op_o = ALU_XOR;
                        F3_SRI: begin
                            imm_fmt_o = IMM_I_SHR;
                            if (funct7 == F7_BASE) begin
                                alu_op_o = ALU_SRL;
                            end else if (funct7 == F7_ALT) begin
                                alu_op_o = ALU_SRA;
                            end
                        end
                        F3_ORI:   if (f7_base) alu_op_o = ALU_OR;
                        F3_ANDI:  if (f7_base) alu_op_o = ALU_AND;
                    endcase
                    if (cmp_op_o != CMP_NOP) ex_out_sel_o = EX_OUT_CMP; // Set-less-than result
                    if (alu_op_o != ALU_NOP || cmp_op_o != CMP_NOP) gpr_we_n_o = 1'b0;
                end
                OP_JALR: begin
                    src_reg_used_o = 2'b01;
                    if (funct3 == F3_JALR) begin
                        alu_op_o     = ALU_ADD; // Target ra + imm, bit 0 cleared
                        src_b_o      = SRC_B_IMM;
                        imm_fmt_o    = IMM_I_JR;
                        ex_out_sel_o = EX_OUT_PCN;
                        gpr_we_n_o   = 1'b0;
                        jump_taken_o = 1'b1;
                    end
                end
                OP_JAL: begin
                    alu_op_o     = ALU_ADD; // Target pc + imm
                    src_a_o      = SRC_A_PC;
                    src_b_o      = SRC_B_IMM;
                    imm_fmt_o    = IMM_J;
                    ex_out_sel_o = EX_OUT_PCN;
                    gpr_we_n_o   = 1'b0;
                    jump_taken_o = 1'b1;
                end
                OP_LUI: begin
                    imm_fmt_o    = IMM_U;
                    wb_src_o     = WB_IMM; // Immediate goes straight to rd
                    ex_out_sel_o = EX_OUT_PCN;
                    gpr_we_n_o   = 1'b0;
                end
                OP_AUIPC: begin
                    alu_op_o   = ALU_ADD;
                    src_a_o    = SRC_A_PC;
                    src_b_o    = SRC_B_IMM;
                    imm_fmt_o  = IMM_U;
                    gpr_we_n_o = 1'b0;
                end
                OP_STORE: begin
                    src_reg_used_o = 2'b11;
                    src_b_o        = SRC_B_IMM;
                    imm_fmt_o      = IMM_S;
                    case (funct3)
                        F3_SB:   mem_op_o = MEM_SB;
                        F3_SH:   mem_op_o = MEM_SH;
                        F3_SW:   mem_op_o = MEM_SW;
                        default: mem_op_o = MEM_NOP;
                    endcase
                    if (mem_op_o != MEM_NOP) alu_op_o = ALU_ADD;
                end
                OP_BRANCH: begin
                    src_reg_used_o = 2'b11;
                    src_a_o        = SRC_A_PC;
                    src_b_o        = SRC_B_IMM;
                    imm_fmt_o      = IMM_B;
                    case (funct3)
                        F3_BEQ:  cmp_op_o = CMP_EQ;
                        F3_BNE:  cmp_op_o = CMP_NE;
                        F3_BLT:  cmp_op_o = CMP_LT;
                        F3_BGE:  cmp_op_o = CMP_GE;
                        F3_BLTU: cmp_op_o = CMP_LTU;
                        F3_BGEU: cmp_op_o = CMP_GEU;
                        default: cmp_op_o = CMP_NOP;
                    endcase
                    if (cmp_op_o != CMP_NOP) alu_op_o = ALU_ADD; // Branch target only
                end
                default: src_reg_used_o = 2'b11;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/id_decode_pkg.sv
`default_nettype none

package id_decode_pkg;

    // ------------------------------
    // Widths
    // ------------------------------
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // ------------------------------
    // Opcodes and funct codes
    // ------------------------------
    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011,
        OP_ALUI   = 7'b0010011,
        OP_AUIPC  = 7'b0010111,
        OP_STORE  = 7'b0100011,
        OP_ALU    = 7'b0110011,
        OP_LUI    = 7'b0110111,
        OP_BRANCH = 7'b1100011,
        OP_JALR   = 7'b1100111,
        OP_JAL    = 7'b1101111
    } opcode_e;

    localparam logic [2:0] F3_LB    = 3'b000;
    localparam logic [2:0] F3_LH    = 3'b001;
    localparam logic [2:0] F3_LW    = 3'b010;
    localparam logic [2:0] F3_LBU   = 3'b100;
    localparam logic [2:0] F3_LHU   = 3'b101;

    // Register ALU ops use the same funct3 values
    localparam logic [2:0] F3_ADDI  = 3'b000;
    localparam logic [2:0] F3_SLLI  = 3'b001;
    localparam logic [2:0] F3_SLTI  = 3'b010;
    localparam logic [2:0] F3_SLTIU = 3'b011;
    localparam logic [2:0] F3_XORI  = 3'b100;
    localparam logic [2:0] F3_SRI   = 3'b101; // SRLI and SRAI
    localparam logic [2:0] F3_ORI   = 3'b110;
    localparam logic [2:0] F3_ANDI  = 3'b111;

    localparam logic [2:0] F3_JALR  = 3'b000;

    localparam logic [2:0] F3_SB    = 3'b000;
    localparam logic [2:0] F3_SH    = 3'b001;
    localparam logic [2:0] F3_SW    = 3'b010;

    localparam logic [2:0] F3_BEQ   = 3'b000;
    localparam logic [2:0] F3_BNE   = 3'b001;
    localparam logic [2:0] F3_BLT   = 3'b100;
    localparam logic [2:0] F3_BGE   = 3'b101;
    localparam logic [2:0] F3_BLTU  = 3'b110;
    localparam logic [2:0] F3_BGEU  = 3'b111;

    localparam logic [6:0] F7_BASE  = 7'b0000000;
    localparam logic [6:0] F7_ALT   = 7'b0100000; // SUB and SRA

    // ------------------------------
    // Decode results
    // ------------------------------
    typedef enum logic [3:0] {
        ALU_NOP, ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA, ALU_XOR, ALU_OR, ALU_AND
    } alu_op_e;

    typedef enum logic [2:0] {
        CMP_NOP, CMP_EQ, CMP_NE, CMP_LT, CMP_GE, CMP_LTU, CMP_GEU
    } cmp_op_e;

    typedef enum logic [3:0] {
        MEM_NOP, MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU, MEM_SB, MEM_SH, MEM_SW
    } mem_op_e;

    typedef enum logic [1:0] {EX_OUT_ALU, EX_OUT_CMP, EX_OUT_PCN} ex_out_sel_e;

    typedef enum logic [2:0] {
        IMM_I, IMM_I_JR, IMM_I_SHR, IMM_S, IMM_B, IMM_U, IMM_J
    } imm_fmt_e;

    typedef enum logic {SRC_A_RA, SRC_A_PC} src_a_e;
    typedef enum logic {SRC_B_RB, SRC_B_IMM} src_b_e;
    typedef enum logic {WB_LINK, WB_IMM} wb_src_e;

endpackage

`default_nettype wire

// File: source/id_ex_reg.sv
`timescale 1ns/1ps
`default_nettype none

module id_ex_reg (
    input  logic                                 clk_i,
    input  logic                                 rst_n_i,
    input  logic                                 valid_i,
    input  id_decode_pkg::alu_op_e               alu_op_i,
    input  logic [id_decode_pkg::XLEN-1:0]       alu_in_0_i,
    input  logic [id_decode_pkg::XLEN-1:0]       alu_in_1_i,
    input  id_decode_pkg::cmp_op_e               cmp_op_i,
    input  logic [id_decode_pkg::XLEN-1:0]       cmp_in_0_i,
    input  logic [id_decode_pkg::XLEN-1:0]       cmp_in_1_i,
    input  id_decode_pkg::mem_op_e               mem_op_i,
    input  logic [id_decode_pkg::XLEN-1:0]       mem_wr_data_i,
    input  id_decode_pkg::ex_out_sel_e           ex_out_sel_i,
    input  logic [id_decode_pkg::XLEN-1:0]       gpr_wr_data_i,
    input  logic [id_decode_pkg::REG_ADDR_W-1:0] dst_addr_i,
    input  logic                                 gpr_we_n_i,
    input  logic                                 jump_taken_i,
    input  logic [1:0]                           src_reg_used_i,
    output logic                                 id_valid_o,
    output id_decode_pkg::alu_op_e               alu_op_o,
    output logic [id_decode_pkg::XLEN-1:0]       alu_in_0_o,
    output logic [id_decode_pkg::XLEN-1:0]       alu_in_1_o,
    output id_decode_pkg::cmp_op_e               cmp_op_o,
    output logic [id_decode_pkg::XLEN-1:0]       cmp_in_0_o,
    output logic [id_decode_pkg::XLEN-1:0]       cmp_in_1_o,
    output id_decode_pkg::mem_op_e               mem_op_o,
    output logic [id_decode_pkg::XLEN-1:0]       mem_wr_data_o,
    output id_decode_pkg::ex_out_sel_e           ex_out_sel_o,
    output logic [id_decode_pkg::XLEN-1:0]       gpr_wr_data_o,
    output logic [id_decode_pkg::REG_ADDR_W-1:0] dst_addr_o,
    output logic                                 gpr_we_n_o,
    output logic                                 jump_taken_o,
    output logic [1:0]                           src_reg_used_o
);

    import id_decode_pkg::*;

    // ------------------------------
    // Control fields
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            id_valid_o     <= 1'b0;
            alu_op_o       <= ALU_NOP;
            cmp_op_o       <= CMP_NOP;
            mem_op_o       <= MEM_NOP;
            ex_out_sel_o   <= EX_OUT_ALU;
            gpr_we_n_o     <= 1'b1;    // No write out of reset
            jump_taken_o   <= 1'b0;
            src_reg_used_o <= 2'b00;
        end else begin
            id_valid_o     <= valid_i;
            alu_op_o       <= alu_op_i;
            cmp_op_o       <= cmp_op_i;
            mem_op_o       <= mem_op_i;
            ex_out_sel_o   <= ex_out_sel_i;
            gpr_we_n_o     <= gpr_we_n_i;
            jump_taken_o   <= jump_taken_i;
            src_reg_used_o <= src_reg_used_i;
        end
    end

    // ------------------------------
    // Data fields
    // ------------------------------
    always_ff @(posedge clk_i) begin
        alu_in_0_o    <= alu_in_0_i;
        alu_in_1_o    <= alu_in_1_i;
        cmp_in_0_o    <= cmp_in_0_i;
        cmp_in_1_o    <= cmp_in_1_i;
        mem_wr_data_o <= mem_wr_data_i;
        gpr_wr_data_o <= gpr_wr_data_i;
        dst_addr_o    <= dst_addr_i;
    end

endmodule

`default_nettype wire

// File: source/id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage (
    input  logic                                 clk_i,
    input  logic                                 rst_n_i,
    input  logic                                 if_en_i,
    input  logic [id_decode_pkg::XLEN-1:0]       if_insn_i,
    input  logic [id_decode_pkg::XLEN-1:0]       insn_pc_i,
    input  logic [id_decode_pkg::XLEN-1:0]       link_pc_i,
    input  logic [id_decode_pkg::XLEN-1:0]       ra_data_i,
    input  logic [id_decode_pkg::XLEN-1:0]       rb_data_i,
    output logic [id_decode_pkg::REG_ADDR_W-1:0] ra_addr_o,
    output logic [id_decode_pkg::REG_ADDR_W-1:0] rb_addr_o,
    output logic                                 id_valid_o,
    output id_decode_pkg::alu_op_e               alu_op_o,
    output logic [id_decode_pkg::XLEN-1:0]       alu_in_0_o,
    output logic [id_decode_pkg::XLEN-1:0]       alu_in_1_o,
    output id_decode_pkg::cmp_op_e               cmp_op_o,
    output logic [id_decode_pkg::XLEN-1:0]       cmp_in_0_o,
    output logic [id_decode_pkg::XLEN-1:0]       cmp_in_1_o,
    output id_decode_pkg::mem_op_e               mem_op_o,
    output logic [id_decode_pkg::XLEN-1:0]       mem_wr_data_o,
    output id_decode_pkg::ex_out_sel_e           ex_out_sel_o,
    output logic [id_decode_pkg::XLEN-1:0]       gpr_wr_data_o,
    output logic [id_decode_pkg::REG_ADDR_W-1:0] dst_addr_o,
    output logic                                 gpr_we_n_o,
    output logic                                 jump_taken_o,
    output logic [1:0]                           src_reg_used_o
);

    import id_decode_pkg::*;

    alu_op_e         dec_alu_op;
    cmp_op_e         dec_cmp_op;
    mem_op_e         dec_mem_op;
    ex_out_sel_e     dec_ex_out_sel;
    imm_fmt_e        dec_imm_fmt;
    src_a_e          dec_src_a;
    src_b_e          dec_src_b;
    wb_src_e         dec_wb_src;
    logic            dec_gpr_we_n;
    logic            dec_jump_taken;
    logic [1:0]      dec_src_reg_used;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] alu_in_0;
    logic [XLEN-1:0] alu_in_1;
    logic [XLEN-1:0] cmp_in_0;
    logic [XLEN-1:0] cmp_in_1;
    logic [XLEN-1:0] mem_wr_data;
    logic [XLEN-1:0] gpr_wr_data;

    assign ra_addr_o = if_insn_i[19:15]; // Register file read, same cycle
    assign rb_addr_o = if_insn_i[24:20];

    ctrl_decoder u_ctrl_decoder (
        .insn_i         (if_insn_i),
        .en_i           (if_en_i),
        .alu_op_o       (dec_alu_op),
        .cmp_op_o       (dec_cmp_op),
        .mem_op_o       (dec_mem_op),
        .ex_out_sel_o   (dec_ex_out_sel),
        .imm_fmt_o      (dec_imm_fmt),
        .src_a_o        (dec_src_a),
        .src_b_o        (dec_src_b),
        .wb_src_o       (dec_wb_src),
        .gpr_we_n_o     (dec_gpr_we_n),
        .jump_taken_o   (dec_jump_taken),
        .src_reg_used_o (dec_src_reg_used)
    );

    imm_gen u_imm_gen (
        .insn_i    (if_insn_i),
        .imm_fmt_i (dec_imm_fmt),
        .imm_o     (imm)
    );

    operand_mux u_operand_mux (
        .ra_data_i     (ra_data_i),
        .rb_data_i     (rb_data_i),
        .insn_pc_i     (insn_pc_i),
        .link_pc_i     (link_pc_i),
        .imm_i         (imm),
        .src_a_i       (dec_src_a),
        .src_b_i       (dec_src_b),
        .wb_src_i      (dec_wb_src),
        .alu_in_0_o    (alu_in_0),
        .alu_in_1_o    (alu_in_1),
        .cmp_in_0_o    (cmp_in_0),
        .cmp_in_1_o    (cmp_in_1),
        .mem_wr_data_o (mem_wr_data),
        .gpr_wr_data_o (gpr_wr_data)
    );

    id_ex_reg u_id_ex_reg (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .valid_i        (if_en_i),
        .alu_op_i       (dec_alu_op),
        .alu_in_0_i     (alu_in_0),
        .alu_in_1_i     (alu_in_1),
        .cmp_op_i       (dec_cmp_op),
        .cmp_in_0_i     (cmp_in_0),
        .cmp_in_1_i     (cmp_in_1),
        .mem_op_i       (dec_mem_op),
        .mem_wr_data_i  (mem_wr_data),
        .ex_out_sel_i   (dec_ex_out_sel),
        .gpr_wr_data_i  (gpr_wr_data),
        .dst_addr_i     (if_insn_i[11:7]), // rd field
        .gpr_we_n_i     (dec_gpr_we_n),
        .jump_taken_i   (dec_jump_taken),
        .src_reg_used_i (dec_src_reg_used),
        .id_valid_o     (id_valid_o),
        .alu_op_o       (alu_op_o),
        .alu_in_0_o     (alu_in_0_o),
        .alu_in_1_o     (alu_in_1_o),
        .cmp_op_o       (cmp_op_o),
        .cmp_in_0_o     (cmp_in_0_o),
        .cmp_in_1_o     (cmp_in_1_o),
        .mem_op_o       (mem_op_o),
        .mem_wr_data_o  (mem_wr_data_o),
        .ex_out_sel_o   (ex_out_sel_o),
        .gpr_wr_data_o  (gpr_wr_data_o),
        .dst_addr_o     (dst_addr_o),
        .gpr_we_n_o     (gpr_we_n_o),
        .jump_taken_o   (jump_taken_o),
        .src_reg_used_o (src_reg_used_o)
    );

endmodule

`default_nettype wire

// File: source/imm_gen.sv
`timescale 1ns/1ps
`default_nettype none

module imm_gen (
    input  logic [id_decode_pkg::XLEN-1:0] insn_i,
    input  id_decode_pkg::imm_fmt_e        imm_fmt_i,
    output logic [id_decode_pkg::XLEN-1:0] imm_o
);

    import id_decode_pkg::*;

    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_i_jr;
    logic [XLEN-1:0] imm_i_shr;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;

    assign imm_i     = {{20{insn_i[31]}}, insn_i[31:20]};
    assign imm_i_jr  = {{20{insn_i[31]}}, insn_i[31:21], 1'b0}; // Bit 0 forced low
    assign imm_i_shr = {{27{insn_i[31]}}, insn_i[24:20]};       // shamt only
    assign imm_s     = {{20{insn_i[31]}}, insn_i[31:25], insn_i[11:7]};
    assign imm_b     = {{20{insn_i[31]}}, insn_i[7], insn_i[30:25], insn_i[11:8], 1'b0};
    assign imm_u     = {insn_i[31:12], 12'b0};
    assign imm_j     = {{12{insn_i[31]}}, insn_i[19:12], insn_i[20], insn_i[30:21], 1'b0};

    always_comb begin
        case (imm_fmt_i)
            IMM_I_JR:  imm_o = imm_i_jr;
            IMM_I_SHR: imm_o = imm_i_shr;
            IMM_S:     imm_o = imm_s;
            IMM_B:     imm_o = imm_b;
            IMM_U:     imm_o = imm_u;
            IMM_J:     imm_o = imm_j;
            default:   imm_o = imm_i;
        endcase
    end

endmodule

`default_nettype wire

// File: source/operand_mux.sv
`timescale 1ns/1ps
`default_nettype none

module operand_mux (
    input  logic [id_decode_pkg::XLEN-1:0] ra_data_i,
    input  logic [id_decode_pkg::XLEN-1:0] rb_data_i,
    input  logic [id_decode_pkg::XLEN-1:0] insn_pc_i,
    input  logic [id_decode_pkg::XLEN-1:0] link_pc_i,
    input  logic [id_decode_pkg::XLEN-1:0] imm_i,
    input  id_decode_pkg::src_a_e          src_a_i,
    input  id_decode_pkg::src_b_e          src_b_i,
    input  id_decode_pkg::wb_src_e         wb_src_i,
    output logic [id_decode_pkg::XLEN-1:0] alu_in_0_o,
    output logic [id_decode_pkg::XLEN-1:0] alu_in_1_o,
    output logic [id_decode_pkg::XLEN-1:0] cmp_in_0_o,
    output logic [id_decode_pkg::XLEN-1:0] cmp_in_1_o,
    output logic [id_decode_pkg::XLEN-1:0] mem_wr_data_o,
    output logic [id_decode_pkg::XLEN-1:0] gpr_wr_data_o
);

    import id_decode_pkg::*;

    logic cmp_use_imm;

    // PC-relative forms (branches) compare ra against rb; the
    // immediate feeds the compare only for SLTI and SLTIU
    assign cmp_use_imm = (src_b_i == SRC_B_IMM) && (src_a_i == SRC_A_RA);

    assign alu_in_0_o    = (src_a_i == SRC_A_PC) ? insn_pc_i : ra_data_i;
    assign alu_in_1_o    = (src_b_i == SRC_B_IMM) ? imm_i : rb_data_i;
    assign cmp_in_0_o    = ra_data_i;
    assign cmp_in_1_o    = cmp_use_imm ? imm_i : rb_data_i;
    assign mem_wr_data_o = rb_data_i;                                 // Store data
    assign gpr_wr_data_o = (wb_src_i == WB_IMM) ? imm_i : link_pc_i; // LUI or link

endmodule

`default_nettype wire

// File: testbench/id_stage_testdata.txt
# en insn pc link ra rb | expected alu cmp mem ex_sel we_n jump src_used
# alu_in_0 alu_in_1 cmp_in_1 gpr_wr_data (all hex)
1 00812283 00001000 00001004 00000200 00000034 1 0 3 0 0 0 1 00000200 00000008 00000008 00001004
1 ffc1c303 00001000 00001004 00000200 00000034 1 0 4 0 0 0 1 00000200 fffffffc fffffffc 00001004
1 00813283 00001000 00001004 00000200 00000034 0 0 0 0 1 0 1 00000200 00000008 00000008 00001004
1 00412623 00001000 00001004 00000200 00000034 1 0 8 0 1 0 3 00000200 0000000c 0000000c 00001004
1 fe518fa3 00001000 00001004 00000200 a5a5a5a5 1 0 6 0 1 0 3 00000200 ffffffff ffffffff 00001004
1 ff010093 00001000 00001004 00000200 00000034 1 0 0 0 0 0 1 00000200 fffffff0 fffffff0 00001004
1 0f02c213 00001000 00001004 00000200 00000034 6 0 0 0 0 0 1 00000200 000000f0 000000f0 00001004
1 0054b413 00001000 00001004 00000200 00000034 0 5 0 1 0 0 1 00000200 00000005 00000005 00001004
1 4075d513 00001000 00001004 00000200 00000034 5 0 0 0 0 0 1 00000200 00000007 00000007 00001004
0 ff010093 00001000 00001004 00000200 00000034 0 0 0 0 1 0 0 00000200 00000034 00000034 00001004
1 005201b3 00001000 00001004 00000200 00000034 1 0 0 0 0 0 3 00000200 00000034 00000034 00001004
1 405201b3 00001000 00001004 00000200 00000034 2 0 0 0 0 0 3 00000200 00000034 00000034 00001004
1 0083d333 00001000 00001004 00000200 00000034 4 0 0 0 0 0 3 00000200 00000034 00000034 00001004
1 00b524b3 00001000 00001004 00000200 00000034 0 3 0 1 0 0 3 00000200 00000034 00000034 00001004
1 00e6f633 00001000 00001004 00000200 0000f0f0 8 0 0 0 0 0 3 00000200 0000f0f0 0000f0f0 00001004
1 025201b3 00001000 00001004 00000200 00000034 0 0 0 0 1 0 3 00000200 00000034 00000034 00001004
1 00208863 00001000 00001004 00000200 00000034 1 1 0 0 1 0 3 00001000 00000010 00000034 00001004
1 fe41fce3 00002000 00002004 00000200 00000034 1 6 0 0 1 0 3 00002000 fffffff8 00000034 00002004
1 001000ef 00001000 00001004 00000200 00000034 1 0 0 2 0 1 0 00001000 00000800 00000034 00001004
1 035280e7 00001000 00001004 00000200 00000077 1 0 0 2 0 1 1 00000200 00000034 00000034 00001004
1 abcde3b7 00001000 00001004 00000200 00000034 0 0 0 2 0 0 0 00000200 00000034 00000034 abcde000
1 12345417 00001000 00001004 00000200 00000034 1 0 0 0 0 0 0 00001000 12345000 00000034 00001004
1 0000007f 00001000 00001004 00000200 00000034 0 0 0 0 1 0 3 00000200 00000034 00000034 00001004

// File: testbench/tb_id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_id_stage;

    import id_decode_pkg::*;

    localparam int    RESET_CYCLES  = 5;
    localparam int    RESET_TIMEOUT = 20;
    localparam int    MAX_VECTORS   = 1000;
    localparam string DATA_FILE     = "testbench/id_stage_testdata.txt";

    typedef struct packed {
        logic                  valid;
        logic [3:0]            alu_op;
        logic [2:0]            cmp_op;
        logic [3:0]            mem_op;
        logic [1:0]            ex_out_sel;
        logic                  gpr_we_n;
        logic                  jump_taken;
        logic [1:0]            src_reg_used;
        logic [XLEN-1:0]       alu_in_0;
        logic [XLEN-1:0]       alu_in_1;
        logic [XLEN-1:0]       cmp_in_0;
        logic [XLEN-1:0]       cmp_in_1;
        logic [XLEN-1:0]       mem_wr_data;
        logic [XLEN-1:0]       gpr_wr_data;
        logic [REG_ADDR_W-1:0] dst_addr;
    } expect_t;

    // ------------------------------
    // DUT signals
    // ------------------------------
    logic                  clk;
    logic                  rst_n;
    logic                  if_en;
    logic [XLEN-1:0]       if_insn;
    logic [XLEN-1:0]       insn_pc;
    logic [XLEN-1:0]       link_pc;
    logic [XLEN-1:0]       ra_data;
    logic [XLEN-1:0]       rb_data;
    logic [REG_ADDR_W-1:0] ra_addr;
    logic [REG_ADDR_W-1:0] rb_addr;
    logic                  id_valid;
    logic [3:0]            alu_op;
    logic [XLEN-1:0]       alu_in_0;
    logic [XLEN-1:0]       alu_in_1;
    logic [2:0]            cmp_op;
    logic [XLEN-1:0]       cmp_in_0;
    logic [XLEN-1:0]       cmp_in_1;
    logic [3:0]            mem_op;
    logic [XLEN-1:0]       mem_wr_data;
    logic [1:0]            ex_out_sel;
    logic [XLEN-1:0]       gpr_wr_data;
    logic [REG_ADDR_W-1:0] dst_addr;
    logic                  gpr_we_n;
    logic                  jump_taken;
    logic [1:0]            src_reg_used;

    int      check_count = 0;
    int      error_count = 0;
    expect_t pending_q[$]; // Results due one cycle after drive

    id_stage u_id_stage (
        .clk_i (clk), .rst_n_i (rst_n), .if_en_i (if_en), .if_insn_i (if_insn),
        .insn_pc_i (insn_pc), .link_pc_i (link_pc),
        .ra_data_i (ra_data), .rb_data_i (rb_data),
        .ra_addr_o (ra_addr), .rb_addr_o (rb_addr), .id_valid_o (id_valid),
        .alu_op_o (alu_op), .alu_in_0_o (alu_in_0), .alu_in_1_o (alu_in_1),
        .cmp_op_o (cmp_op), .cmp_in_0_o (cmp_in_0), .cmp_in_1_o (cmp_in_1),
        .mem_op_o (mem_op), .mem_wr_data_o (mem_wr_data), .ex_out_sel_o (ex_out_sel),
        .gpr_wr_data_o (gpr_wr_data), .dst_addr_o (dst_addr), .gpr_we_n_o (gpr_we_n),
        .jump_taken_o (jump_taken), .src_reg_used_o (src_reg_used)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk; // 100 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

    // ------------------------------
    // Checking
    // ------------------------------
    task automatic check_equal(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %0t: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic check_idle();
        check_equal("id_valid_o", 32'(id_valid), 32'h0);
        check_equal("gpr_we_n_o", 32'(gpr_we_n), 32'h1);
        check_equal("jump_taken_o", 32'(jump_taken), 32'h0);
        check_equal("alu_op_o", 32'(alu_op), 32'h0);
        check_equal("cmp_op_o", 32'(cmp_op), 32'h0);
        check_equal("mem_op_o", 32'(mem_op), 32'h0);
        check_equal("ex_out_sel_o", 32'(ex_out_sel), 32'h0);
        check_equal("src_reg_used_o", 32'(src_reg_used), 32'h0);
    endtask

    task automatic compare_outputs(input expect_t exp);
        check_equal("id_valid_o", 32'(id_valid), 32'(exp.valid));
        check_equal("alu_op_o", 32'(alu_op), 32'(exp.alu_op));
        check_equal("cmp_op_o", 32'(cmp_op), 32'(exp.cmp_op));
        check_equal("mem_op_o", 32'(mem_op), 32'(exp.mem_op));
        check_equal("ex_out_sel_o", 32'(ex_out_sel), 32'(exp.ex_out_sel));
        check_equal("gpr_we_n_o", 32'(gpr_we_n), 32'(exp.gpr_we_n));
        check_equal("jump_taken_o", 32'(jump_taken), 32'(exp.jump_taken));
        check_equal("src_reg_used_o", 32'(src_reg_used), 32'(exp.src_reg_used));
        check_equal("alu_in_0_o", alu_in_0, exp.alu_in_0);
        check_equal("alu_in_1_o", alu_in_1, exp.alu_in_1);
        check_equal("cmp_in_0_o", cmp_in_0, exp.cmp_in_0);
        check_equal("cmp_in_1_o", cmp_in_1, exp.cmp_in_1);
        check_equal("mem_wr_data_o", mem_wr_data, exp.mem_wr_data);
        check_equal("gpr_wr_data_o", gpr_wr_data, exp.gpr_wr_data);
        check_equal("dst_addr_o", 32'(dst_addr), 32'(exp.dst_addr));
    endtask

    // ------------------------------
    // Stimulus
    // ------------------------------
    initial begin
        expect_t     exp;
        int          fd;
        int          n_fields;
        int          n_vectors;
        int          cycles;
        string       line;
        logic [31:0] f_en, f_insn, f_pc, f_link, f_ra, f_rb;
        logic [31:0] f_alu_op, f_cmp_op, f_mem_op, f_ex_sel, f_we_n, f_jump, f_src_used;
        logic [31:0] f_alu_in_0, f_alu_in_1, f_cmp_in_1, f_wr_data;

        if_en     = 1'b0;
        if_insn   = '0;
        insn_pc   = '0;
        link_pc   = '0;
        ra_data   = '0;
        rb_data   = '0;
        n_vectors = 0;
        cycles    = 0;

        while (rst_n !== 1'b1 && cycles < RESET_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end

        if (rst_n !== 1'b1) begin
            error_count++;
            $display("Reset was not released within %0d cycles", RESET_TIMEOUT);
        end else begin
            check_idle(); // Nothing decoded yet
            fd = $fopen(DATA_FILE, "r");
            if (fd == 0) begin
                error_count++;
                $display("Could not open the test data file %s", DATA_FILE);
            end else begin
                while (!$feof(fd) && n_vectors < MAX_VECTORS) begin
                    line = "";
                    if ($fgets(line, fd) != 0) begin
                        n_fields = $sscanf(line,
                            "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            f_en, f_insn, f_pc, f_link, f_ra, f_rb,
                            f_alu_op, f_cmp_op, f_mem_op, f_ex_sel, f_we_n, f_jump,
                            f_src_used, f_alu_in_0, f_alu_in_1, f_cmp_in_1, f_wr_data);
                        if (n_fields == 17) begin
                            @(posedge clk);
                            if_en   <= f_en[0];
                            if_insn <= f_insn;
                            insn_pc <= f_pc;
                            link_pc <= f_link;
                            ra_data <= f_ra;
                            rb_data <= f_rb;
                            @(negedge clk);
                            check_equal("ra_addr_o", 32'(ra_addr), 32'(f_insn[19:15]));
                            check_equal("rb_addr_o", 32'(rb_addr), 32'(f_insn[24:20]));
                            if (pending_q.size() > 0) compare_outputs(pending_q.pop_front());
                            exp.valid        = f_en[0];
                            exp.alu_op       = f_alu_op[3:0];
                            exp.cmp_op       = f_cmp_op[2:0];
                            exp.mem_op       = f_mem_op[3:0];
                            exp.ex_out_sel   = f_ex_sel[1:0];
                            exp.gpr_we_n     = f_we_n[0];
                            exp.jump_taken   = f_jump[0];
                            exp.src_reg_used = f_src_used[1:0];
                            exp.alu_in_0     = f_alu_in_0;
                            exp.alu_in_1     = f_alu_in_1;
                            exp.cmp_in_0     = f_ra;          // Compare always sees ra
                            exp.cmp_in_1     = f_cmp_in_1;
                            exp.mem_wr_data  = f_rb;          // Store data is rb
                            exp.gpr_wr_data  = f_wr_data;
                            exp.dst_addr     = f_insn[11:7];  // rd field
                            pending_q.push_back(exp);
                            n_vectors++;
                        end else if (n_fields > 0) begin
                            error_count++;
                            $display("Malformed line in test data file: %s", line);
                        end
                    end
                end
                $fclose(fd);

                // Drain the last vector
                @(posedge clk);
                if_en <= 1'b0;
                @(negedge clk);
                if (pending_q.size() > 0) compare_outputs(pending_q.pop_front());

                if (n_vectors == 0) begin
                    error_count++;
                    $display("No vectors were read from the test data file");
                end
            end
        end

        $display("Vectors: %0d, checks: %0d, errors: %0d", n_vectors, check_count, error_count);
        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
